//--- rs.f
+incdir+include
src/rs_pkg.sv
src/rs_issue_if.sv
src/rs_dispatch_router.sv
src/rs_unordered_station.sv
src/rs_mem_queue.sv
src/rs_top.sv
test/tb_rs_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_rs_top -f rs.f -o sim_tb_rs_top
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/sim_tb_rs_top)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "TEST OK" <<< "$sim_out"; then
    exit 0
fi
exit 1

//--- include/rs_tb_tasks.svh
// Xorshift32 for operand data and control words
function automatic word_t next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
endfunction

// Both operands used and already ready
function automatic rs_instr_t ready_instr(input instr_class_t cls, input rob_order_t order);
    rs_instr_t instr;
    word_t     ctrl_bits;
    instr             = '0;
    instr.instr_class = cls;
    instr.order       = order;
    instr.rs1_used    = 1'b1;
    instr.rs1_rdy     = 1'b1;
    instr.rs1_data    = next_rand();
    instr.rs2_used    = 1'b1;
    instr.rs2_rdy     = 1'b1;
    instr.rs2_data    = next_rand();
    ctrl_bits         = next_rand();
    instr.ctrl        = ctrl_bits[15:0];
    return instr;
endfunction

task automatic check_word(input string what, input word_t got, input word_t exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
endtask

task automatic check_order(input string what, input rob_order_t got, input rob_order_t exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
endtask

task automatic check_ctrl(input string what, input ctrl_word_t got, input ctrl_word_t exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
endtask

task automatic check_bit(input string what, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
endtask

task automatic expect_alu_issue(input rs_instr_t exp);
    check_bit("alu valid", alu_issue_valid, 1'b1);
    check_order("alu order", alu_issue_order, exp.order);
    check_word("alu rs1_data", alu_issue_rs1_data, exp.rs1_data);
    check_word("alu rs2_data", alu_issue_rs2_data, exp.rs2_data);
    check_ctrl("alu ctrl", alu_issue_ctrl, exp.ctrl);
endtask

task automatic expect_mul_issue(input rs_instr_t exp);
    check_bit("mul valid", mul_issue_valid, 1'b1);
    check_order("mul order", mul_issue_order, exp.order);
    check_word("mul rs1_data", mul_issue_rs1_data, exp.rs1_data);
    check_word("mul rs2_data", mul_issue_rs2_data, exp.rs2_data);
    check_ctrl("mul ctrl", mul_issue_ctrl, exp.ctrl);
endtask

task automatic expect_mem_issue(input rs_instr_t exp);
    check_bit("mem valid", mem_issue_valid, 1'b1);
    check_order("mem order", mem_issue_order, exp.order);
    check_word("mem rs1_data", mem_issue_rs1_data, exp.rs1_data);
    check_word("mem rs2_data", mem_issue_rs2_data, exp.rs2_data);
    check_ctrl("mem ctrl", mem_issue_ctrl, exp.ctrl);
endtask

task automatic clear_inputs();
    dispatch_valid = 1'b0;
    wb_valid       = 1'b0;
    alu_issue_req  = 1'b0;
    mul_issue_req  = 1'b0;
    mem_issue_req  = 1'b0;
endtask

// Instruction stays on the dispatch port until the caller changes it
task automatic dispatch(input rs_instr_t instr, input logic exp_stall);
    @(negedge clk);
    disp           = instr;
    dispatch_valid = 1'b1;
    #1;
    check_bit("stall", stall, exp_stall);
endtask

task automatic step_mem_issue(input rob_order_t head, input logic exp_valid,
                              input rs_instr_t exp);
    @(negedge clk);
    dispatch_valid = 1'b0;
    wb_valid       = 1'b0;
    mem_issue_req  = 1'b1;
    rob_head_order = head;
    #1;
    if (exp_valid) begin
        expect_mem_issue(exp);
    end else begin
        check_bit("mem valid", mem_issue_valid, 1'b0);
    end
endtask

task automatic report_test(input string name, input int errors_before);
    test_count++;
    $display("test %s finished with %0d errors", name, error_count - errors_before);
endtask

task automatic reset_idle();
    rs_instr_t probe;
    int        errors_before;
    errors_before = error_count;
    probe         = ready_instr(CLASS_ALU, 8'd0);
    @(negedge clk);
    alu_issue_req  = 1'b1;
    mul_issue_req  = 1'b1;
    mem_issue_req  = 1'b1;
    // Empty ALU station must take this dispatch without stalling
    disp           = probe;
    dispatch_valid = 1'b1;
    #1;
    check_bit("stall after reset", stall, 1'b0);
    check_bit("alu valid after reset", alu_issue_valid, 1'b0);
    check_bit("mul valid after reset", mul_issue_valid, 1'b0);
    check_bit("mem valid after reset", mem_issue_valid, 1'b0);
    @(negedge clk);
    dispatch_valid = 1'b0;
    #1;
    expect_alu_issue(probe);
    report_test("reset", errors_before);
endtask

task automatic fill_alu_station();
    rs_instr_t sent [9];
    int        issue_seq [9] = '{0, 1, 8, 2, 3, 4, 5, 6, 7};
    int        errors_before;
    errors_before = error_count;
    for (int i = 0; i < 9; i++) begin
        sent[i] = ready_instr(CLASS_ALU, rob_order_t'(i + 1));
    end
    @(negedge clk);
    clear_inputs();
    for (int i = 0; i < 8; i++) begin
        dispatch(sent[i], 1'b0);
    end
    dispatch(sent[8], 1'b1);
    @(negedge clk);
    alu_issue_req = 1'b1;
    #1;
    check_bit("stall during first issue", stall, 1'b1);
    expect_alu_issue(sent[0]);
    // Freed slot 0 takes the held ninth and issues it next
    @(negedge clk);
    #1;
    check_bit("stall after first issue", stall, 1'b0);
    expect_alu_issue(sent[1]);
    for (int k = 2; k < 9; k++) begin
        @(negedge clk);
        dispatch_valid = 1'b0;
        #1;
        expect_alu_issue(sent[issue_seq[k]]);
    end
    @(negedge clk);
    #1;
    check_bit("alu valid when empty", alu_issue_valid, 1'b0);
    report_test("alu fill and order", errors_before);
endtask

task automatic wake_waiting_operand();
    rs_instr_t waiting;
    rs_instr_t ready;
    word_t     wb_value;
    int        errors_before;
    errors_before     = error_count;
    waiting           = ready_instr(CLASS_ALU, 8'd20);
    waiting.rs1_rdy   = 1'b0;
    waiting.rs1_paddr = 6'd12;
    waiting.rs2_used  = 1'b0;
    waiting.rs2_rdy   = 1'b0;
    ready             = ready_instr(CLASS_ALU, 8'd21);
    wb_value          = next_rand();
    @(negedge clk);
    clear_inputs();
    dispatch(waiting, 1'b0);
    dispatch(ready, 1'b0);
    @(negedge clk);
    dispatch_valid = 1'b0;
    alu_issue_req  = 1'b1;
    #1;
    expect_alu_issue(ready);
    @(negedge clk);
    wb_valid = 1'b1;
    wb_paddr = 6'd12;
    wb_data  = wb_value;
    #1;
    check_bit("alu valid before wakeup", alu_issue_valid, 1'b0);
    @(negedge clk);
    wb_valid = 1'b0;
    #1;
    // Unused rs2 carries nothing of interest
    check_bit("alu valid after wakeup", alu_issue_valid, 1'b1);
    check_order("alu order after wakeup", alu_issue_order, waiting.order);
    check_word("alu rs1_data from writeback", alu_issue_rs1_data, wb_value);
    check_ctrl("alu ctrl after wakeup", alu_issue_ctrl, waiting.ctrl);
    report_test("wakeup and out-of-order issue", errors_before);
endtask

task automatic bypass_dispatch_writeback();
    rs_instr_t waiting;
    rs_instr_t expected;
    int        errors_before;
    errors_before     = error_count;
    waiting           = ready_instr(CLASS_MUL, 8'd30);
    waiting.rs1_rdy   = 1'b0;
    waiting.rs1_paddr = 6'd33;
    expected          = waiting;
    expected.rs1_data = next_rand();
    @(negedge clk);
    clear_inputs();
    disp           = waiting;
    dispatch_valid = 1'b1;
    wb_valid       = 1'b1;
    wb_paddr       = 6'd33;
    wb_data        = expected.rs1_data;
    @(negedge clk);
    dispatch_valid = 1'b0;
    wb_valid       = 1'b0;
    mul_issue_req  = 1'b1;
    #1;
    expect_mul_issue(expected);
    report_test("dispatch bypass", errors_before);
endtask

task automatic order_memory_issue();
    rs_instr_t sent [5];
    int        errors_before;
    errors_before = error_count;
    for (int i = 0; i < 5; i++) begin
        sent[i] = ready_instr(CLASS_MEM, rob_order_t'(40 + i));
    end
    // Fourth one waits on an operand ahead of a ready fifth
    sent[3].rs1_rdy   = 1'b0;
    sent[3].rs1_paddr = 6'd20;
    @(negedge clk);
    clear_inputs();
    for (int i = 0; i < 3; i++) begin
        dispatch(sent[i], 1'b0);
    end
    step_mem_issue(8'd41, 1'b0, sent[0]);
    step_mem_issue(8'd40, 1'b1, sent[0]);
    step_mem_issue(8'd41, 1'b1, sent[1]);
    step_mem_issue(8'd42, 1'b1, sent[2]);
    dispatch(sent[3], 1'b0);
    dispatch(sent[4], 1'b0);
    step_mem_issue(8'd43, 1'b0, sent[3]);
    step_mem_issue(8'd44, 1'b0, sent[4]);
    sent[3].rs1_data = next_rand();
    @(negedge clk);
    rob_head_order = 8'd43;
    wb_valid       = 1'b1;
    wb_paddr       = 6'd20;
    wb_data        = sent[3].rs1_data;
    #1;
    check_bit("mem valid while head wakes", mem_issue_valid, 1'b0);
    step_mem_issue(8'd43, 1'b1, sent[3]);
    step_mem_issue(8'd44, 1'b1, sent[4]);
    report_test("memory order", errors_before);
endtask

task automatic fill_mul_station();
    rs_instr_t sent [5];
    rs_instr_t alu_instr;
    int        errors_before;
    errors_before = error_count;
    for (int i = 0; i < 5; i++) begin
        sent[i] = ready_instr(CLASS_MUL, rob_order_t'(60 + i));
    end
    alu_instr = ready_instr(CLASS_ALU, 8'd70);
    @(negedge clk);
    clear_inputs();
    for (int i = 0; i < 4; i++) begin
        dispatch(sent[i], 1'b0);
    end
    dispatch(sent[4], 1'b1);
    // Full MUL station leaves the ALU path open
    dispatch(alu_instr, 1'b0);
    @(negedge clk);
    dispatch_valid = 1'b0;
    alu_issue_req  = 1'b1;
    mul_issue_req  = 1'b1;
    #1;
    expect_alu_issue(alu_instr);
    expect_mul_issue(sent[0]);
    for (int i = 1; i < 4; i++) begin
        @(negedge clk);
        #1;
        expect_mul_issue(sent[i]);
    end
    @(negedge clk);
    #1;
    check_bit("mul valid when empty", mul_issue_valid, 1'b0);
    report_test("mul capacity", errors_before);
endtask

//--- test/tb_rs_top.sv
`timescale 1ns/100ps

module tb_rs_top;
    import rs_pkg::*;

    // The tests take on the order of a hundred cycles
    localparam int MAX_CYCLES = 2000;

    logic       clk;
    logic       rst;
    logic       dispatch_valid;
    rs_instr_t  disp;
    logic       stall;
    logic       wb_valid;
    phys_reg_t  wb_paddr;
    word_t      wb_data;
    rob_order_t rob_head_order;

    logic       alu_issue_req, mul_issue_req, mem_issue_req;
    logic       alu_issue_valid, mul_issue_valid, mem_issue_valid;
    rob_order_t alu_issue_order, mul_issue_order, mem_issue_order;
    word_t      alu_issue_rs1_data, mul_issue_rs1_data, mem_issue_rs1_data;
    word_t      alu_issue_rs2_data, mul_issue_rs2_data, mem_issue_rs2_data;
    ctrl_word_t alu_issue_ctrl, mul_issue_ctrl, mem_issue_ctrl;

    int    error_count = 0;
    int    check_count = 0;
    int    test_count  = 0;
    int    cycle_count = 0;
    word_t rng_state   = 32'd73764;

    rs_top rs_top_i (
        .*,
        .dispatch_class     (disp.instr_class),
        .dispatch_order     (disp.order),
        .dispatch_rs1_used  (disp.rs1_used),
        .dispatch_rs1_rdy   (disp.rs1_rdy),
        .dispatch_rs1_paddr (disp.rs1_paddr),
        .dispatch_rs1_data  (disp.rs1_data),
        .dispatch_rs2_used  (disp.rs2_used),
        .dispatch_rs2_rdy   (disp.rs2_rdy),
        .dispatch_rs2_paddr (disp.rs2_paddr),
        .dispatch_rs2_data  (disp.rs2_data),
        .dispatch_ctrl      (disp.ctrl)
    );

    `include "rs_tb_tasks.svh"

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout, the run was stopped after %0d cycles", cycle_count);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        dispatch_valid = 1'b0;
        disp           = '0;
        wb_valid       = 1'b0;
        wb_paddr       = '0;
        wb_data        = '0;
        rob_head_order = '0;
        alu_issue_req  = 1'b0;
        mul_issue_req  = 1'b0;
        mem_issue_req  = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        reset_idle();
        fill_alu_station();
        wake_waiting_operand();
        bypass_dispatch_writeback();
        order_memory_issue();
        fill_mul_station();

        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- src/rs_top.sv
`timescale 1ns/100ps

module rs_top #(
    parameter int ALU_ENTRY_BITS = 3,
    parameter int MUL_ENTRY_BITS = 2,
    parameter int MEM_ENTRY_BITS = 4
) (
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 dispatch_valid,
    input  rs_pkg::instr_class_t dispatch_class,
    input  rs_pkg::rob_order_t   dispatch_order,
    input  logic                 dispatch_rs1_used,
    input  logic                 dispatch_rs1_rdy,
    input  rs_pkg::phys_reg_t    dispatch_rs1_paddr,
    input  rs_pkg::word_t        dispatch_rs1_data,
    input  logic                 dispatch_rs2_used,
    input  logic                 dispatch_rs2_rdy,
    input  rs_pkg::phys_reg_t    dispatch_rs2_paddr,
    input  rs_pkg::word_t        dispatch_rs2_data,
    input  rs_pkg::ctrl_word_t   dispatch_ctrl,
    output logic                 stall,

    input  logic                 wb_valid,
    input  rs_pkg::phys_reg_t    wb_paddr,
    input  rs_pkg::word_t        wb_data,

    input  rs_pkg::rob_order_t   rob_head_order,

    input  logic                 alu_issue_req,
    output logic                 alu_issue_valid,
    output rs_pkg::rob_order_t   alu_issue_order,
    output rs_pkg::word_t        alu_issue_rs1_data,
    output rs_pkg::word_t        alu_issue_rs2_data,
    output rs_pkg::ctrl_word_t   alu_issue_ctrl,

    input  logic                 mul_issue_req,
    output logic                 mul_issue_valid,
    output rs_pkg::rob_order_t   mul_issue_order,
    output rs_pkg::word_t        mul_issue_rs1_data,
    output rs_pkg::word_t        mul_issue_rs2_data,
    output rs_pkg::ctrl_word_t   mul_issue_ctrl,

    input  logic                 mem_issue_req,
    output logic                 mem_issue_valid,
    output rs_pkg::rob_order_t   mem_issue_order,
    output rs_pkg::word_t        mem_issue_rs1_data,
    output rs_pkg::word_t        mem_issue_rs2_data,
    output rs_pkg::ctrl_word_t   mem_issue_ctrl
);
    import rs_pkg::*;

    rs_instr_t dispatch_instr;
    rs_instr_t push_instr;
    logic      alu_push, mul_push, mem_push;
    logic      alu_full, mul_full, mem_full;

    rs_issue_if alu_issue ();
    rs_issue_if mul_issue ();
    rs_issue_if mem_issue ();

    assign dispatch_instr = '{
        instr_class: dispatch_class,
        order:       dispatch_order,
        rs1_used:    dispatch_rs1_used,
        rs1_rdy:     dispatch_rs1_rdy,
        rs1_paddr:   dispatch_rs1_paddr,
        rs1_data:    dispatch_rs1_data,
        rs2_used:    dispatch_rs2_used,
        rs2_rdy:     dispatch_rs2_rdy,
        rs2_paddr:   dispatch_rs2_paddr,
        rs2_data:    dispatch_rs2_data,
        ctrl:        dispatch_ctrl
    };

    rs_dispatch_router rs_dispatch_router_i (
        .dispatch_valid (dispatch_valid),
        .dispatch_instr (dispatch_instr),
        .wb_valid       (wb_valid),
        .wb_paddr       (wb_paddr),
        .wb_data        (wb_data),
        .alu_full       (alu_full),
        .mul_full       (mul_full),
        .mem_full       (mem_full),
        .alu_push       (alu_push),
        .mul_push       (mul_push),
        .mem_push       (mem_push),
        .push_instr     (push_instr),
        .stall          (stall)
    );

    rs_unordered_station #(.ENTRY_BITS(ALU_ENTRY_BITS)) alu_station_i (
        .clk        (clk),
        .rst        (rst),
        .push       (alu_push),
        .push_instr (push_instr),
        .wb_valid   (wb_valid),
        .wb_paddr   (wb_paddr),
        .wb_data    (wb_data),
        .full       (alu_full),
        .issue      (alu_issue.station)
    );

    rs_unordered_station #(.ENTRY_BITS(MUL_ENTRY_BITS)) mul_station_i (
        .clk        (clk),
        .rst        (rst),
        .push       (mul_push),
        .push_instr (push_instr),
        .wb_valid   (wb_valid),
        .wb_paddr   (wb_paddr),
        .wb_data    (wb_data),
        .full       (mul_full),
        .issue      (mul_issue.station)
    );

    // In-order queue for loads and stores
    rs_mem_queue #(.ENTRY_BITS(MEM_ENTRY_BITS)) mem_queue_i (
        .clk            (clk),
        .rst            (rst),
        .push           (mem_push),
        .push_instr     (push_instr),
        .wb_valid       (wb_valid),
        .wb_paddr       (wb_paddr),
        .wb_data        (wb_data),
        .rob_head_order (rob_head_order),
        .full           (mem_full),
        .issue          (mem_issue.station)
    );

    // FU side of each issue port
    assign alu_issue.req      = alu_issue_req;
    assign alu_issue_valid    = alu_issue.valid;
    assign alu_issue_order    = alu_issue.order;
    assign alu_issue_rs1_data = alu_issue.rs1_data;
    assign alu_issue_rs2_data = alu_issue.rs2_data;
    assign alu_issue_ctrl     = alu_issue.ctrl;

    assign mul_issue.req      = mul_issue_req;
    assign mul_issue_valid    = mul_issue.valid;
    assign mul_issue_order    = mul_issue.order;
    assign mul_issue_rs1_data = mul_issue.rs1_data;
    assign mul_issue_rs2_data = mul_issue.rs2_data;
    assign mul_issue_ctrl     = mul_issue.ctrl;

    assign mem_issue.req      = mem_issue_req;
    assign mem_issue_valid    = mem_issue.valid;
    assign mem_issue_order    = mem_issue.order;
    assign mem_issue_rs1_data = mem_issue.rs1_data;
    assign mem_issue_rs2_data = mem_issue.rs2_data;
    assign mem_issue_ctrl     = mem_issue.ctrl;

endmodule

//--- src/rs_mem_queue.sv
`timescale 1ns/100ps

module rs_mem_queue #(
    parameter int ENTRY_BITS = 4
) (
    input  logic               clk,
    input  logic               rst,

    input  logic               push,
    input  rs_pkg::rs_instr_t  push_instr,

    input  logic               wb_valid,
    input  rs_pkg::phys_reg_t  wb_paddr,
    input  rs_pkg::word_t      wb_data,

    input  rs_pkg::rob_order_t rob_head_order,

    output logic               full,
    rs_issue_if.station        issue
);
    import rs_pkg::*;

    localparam int NUM_ENTRIES = 2 ** ENTRY_BITS;

    // Pointers carry one wrap bit above the slot index
    typedef logic [ENTRY_BITS:0]   ptr_t;
    typedef logic [ENTRY_BITS-1:0] slot_t;

    rs_instr_t              entries [NUM_ENTRIES];
    logic [NUM_ENTRIES-1:0] entry_valid;
    ptr_t                   head;
    ptr_t                   tail;
    slot_t                  head_idx;
    slot_t                  tail_idx;
    logic                   empty;
    rs_instr_t              head_instr;
    logic                   do_issue;

    assign head_idx = head[ENTRY_BITS-1:0];
    assign tail_idx = tail[ENTRY_BITS-1:0];

    assign full  = (head[ENTRY_BITS] != tail[ENTRY_BITS]) && (head_idx == tail_idx);
    assign empty = (head == tail);

    assign head_instr = entries[head_idx];

    // Memory ops leave in program order, and only at the ROB head
    assign do_issue = issue.req && !empty && entry_valid[head_idx]
                      && operands_ready(head_instr)
                      && (head_instr.order == rob_head_order);

    assign issue.valid    = do_issue;
    assign issue.order    = do_issue ? head_instr.order    : '0;
    assign issue.rs1_data = do_issue ? head_instr.rs1_data : '0;
    assign issue.rs2_data = do_issue ? head_instr.rs2_data : '0;
    assign issue.ctrl     = do_issue ? head_instr.ctrl     : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            entry_valid <= '0;
            head        <= '0;
            tail        <= '0;
        end else begin
            if (push) begin
                entry_valid[tail_idx] <= 1'b1;
                tail                  <= tail + ptr_t'(1);
            end
            if (do_issue) begin
                entry_valid[head_idx] <= 1'b0;
                head                  <= head + ptr_t'(1);
            end
        end
    end

    // Wakeup reaches every queued entry, not only the head
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (entry_valid[i]) begin
                entries[i] <= operand_wakeup(entries[i], wb_valid, wb_paddr, wb_data);
            end
        end
        if (push) begin
            entries[tail_idx] <= push_instr;
        end
    end

endmodule

//--- src/rs_unordered_station.sv
`timescale 1ns/100ps

module rs_unordered_station #(
    parameter int ENTRY_BITS = 3
) (
    input  logic              clk,
    input  logic              rst,

    input  logic              push,
    input  rs_pkg::rs_instr_t push_instr,

    input  logic              wb_valid,
    input  rs_pkg::phys_reg_t wb_paddr,
    input  rs_pkg::word_t     wb_data,

    output logic              full,
    rs_issue_if.station       issue
);
    import rs_pkg::*;

    localparam int NUM_ENTRIES = 2 ** ENTRY_BITS;

    typedef logic [ENTRY_BITS-1:0] slot_t;

    rs_instr_t              entries [NUM_ENTRIES];
    logic [NUM_ENTRIES-1:0] entry_valid;
    logic [NUM_ENTRIES-1:0] entry_ready;
    slot_t                  free_idx;
    slot_t                  issue_idx;
    logic                   do_issue;

    assign full = &entry_valid;

    always_comb begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            entry_ready[i] = entry_valid[i] && operands_ready(entries[i]);
        end
    end

    // Lowest free slot, scanned downward so the last hit wins
    always_comb begin
        free_idx = '0;
        for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
            if (!entry_valid[i]) begin
                free_idx = slot_t'(i);
            end
        end
    end

    // Lowest ready entry
    always_comb begin
        issue_idx = '0;
        for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
            if (entry_ready[i]) begin
                issue_idx = slot_t'(i);
            end
        end
    end

    assign do_issue = issue.req && (|entry_ready);

    // Outputs read as zero unless an entry goes out
    assign issue.valid    = do_issue;
    assign issue.order    = do_issue ? entries[issue_idx].order    : '0;
    assign issue.rs1_data = do_issue ? entries[issue_idx].rs1_data : '0;
    assign issue.rs2_data = do_issue ? entries[issue_idx].rs2_data : '0;
    assign issue.ctrl     = do_issue ? entries[issue_idx].ctrl     : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            entry_valid <= '0;
        end else begin
            if (do_issue) begin
                entry_valid[issue_idx] <= 1'b0;
            end
            // Free slot is never the issued one
            if (push) begin
                entry_valid[free_idx] <= 1'b1;
            end
        end
    end

    // Waiting entries keep listening to the writeback bus
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (entry_valid[i]) begin
                entries[i] <= operand_wakeup(entries[i], wb_valid, wb_paddr, wb_data);
            end
        end
        if (push) begin
            entries[free_idx] <= push_instr;
        end
    end

endmodule

//--- src/rs_dispatch_router.sv
`timescale 1ns/100ps

module rs_dispatch_router (
    input  logic              dispatch_valid,
    input  rs_pkg::rs_instr_t dispatch_instr,

    input  logic              wb_valid,
    input  rs_pkg::phys_reg_t wb_paddr,
    input  rs_pkg::word_t     wb_data,

    input  logic              alu_full,
    input  logic              mul_full,
    input  logic              mem_full,

    output logic              alu_push,
    output logic              mul_push,
    output logic              mem_push,
    output rs_pkg::rs_instr_t push_instr,
    output logic              stall
);
    import rs_pkg::*;

    logic target_full;

    // Same-cycle writeback merged before the entry is stored
    assign push_instr = operand_wakeup(dispatch_instr, wb_valid, wb_paddr, wb_data);

    always_comb begin
        case (dispatch_instr.instr_class)
            CLASS_ALU: target_full = alu_full;
            CLASS_MUL: target_full = mul_full;
            CLASS_MEM: target_full = mem_full;
            default:   target_full = 1'b0;
        endcase
    end

    // Stall only for the class being dispatched
    assign stall = dispatch_valid && target_full;

    always_comb begin
        alu_push = 1'b0;
        mul_push = 1'b0;
        mem_push = 1'b0;
        if (dispatch_valid && !target_full) begin
            case (dispatch_instr.instr_class)
                CLASS_ALU: alu_push = 1'b1;
                CLASS_MUL: mul_push = 1'b1;
                CLASS_MEM: mem_push = 1'b1;
                // Unrouted code is simply dropped
                default: ;
            endcase
        end
    end

endmodule

//--- src/rs_issue_if.sv
`timescale 1ns/100ps

// One station to FU issue port, valid answers req in the same cycle
interface rs_issue_if;

    logic                req;
    logic                valid;
    rs_pkg::rob_order_t  order;
    rs_pkg::word_t       rs1_data;
    rs_pkg::word_t       rs2_data;
    rs_pkg::ctrl_word_t  ctrl;

    modport station (
        input  req,
        output valid, order, rs1_data, rs2_data, ctrl
    );

    modport fu (
        output req,
        input  valid, order, rs1_data, rs2_data, ctrl
    );

endinterface

//--- src/rs_pkg.sv
package rs_pkg;

    // Widths that carry a meaning
    typedef logic [31:0] word_t;
    typedef logic [5:0]  phys_reg_t;
    typedef logic [7:0]  rob_order_t;
    typedef logic [1:0]  instr_class_t;
    typedef logic [15:0] ctrl_word_t;

    // Station routing codes, code 3 goes nowhere
    localparam instr_class_t CLASS_ALU = 2'd0;
    localparam instr_class_t CLASS_MUL = 2'd1;
    localparam instr_class_t CLASS_MEM = 2'd2;

    // One waiting instruction with its operand tags and values
    typedef struct packed {
        instr_class_t instr_class;
        rob_order_t   order;
        logic         rs1_used;
        logic         rs1_rdy;
        phys_reg_t    rs1_paddr;
        word_t        rs1_data;
        logic         rs2_used;
        logic         rs2_rdy;
        phys_reg_t    rs2_paddr;
        word_t        rs2_data;
        ctrl_word_t   ctrl;
    } rs_instr_t;

    // Capture a writeback into any operand still waiting on its tag
    function automatic rs_instr_t operand_wakeup(
        input rs_instr_t instr,
        input logic      wb_valid,
        input phys_reg_t wb_paddr,
        input word_t     wb_data
    );
        rs_instr_t woken;
        woken = instr;
        if (wb_valid && instr.rs1_used && !instr.rs1_rdy && instr.rs1_paddr == wb_paddr) begin
            woken.rs1_rdy  = 1'b1;
            woken.rs1_data = wb_data;
        end
        if (wb_valid && instr.rs2_used && !instr.rs2_rdy && instr.rs2_paddr == wb_paddr) begin
            woken.rs2_rdy  = 1'b1;
            woken.rs2_data = wb_data;
        end
        return woken;
    endfunction

    // Unused operands never hold an instruction back
    function automatic logic operands_ready(input rs_instr_t instr);
        logic rs1_ok;
        logic rs2_ok;
        rs1_ok = !instr.rs1_used || instr.rs1_rdy;
        rs2_ok = !instr.rs2_used || instr.rs2_rdy;
        return rs1_ok && rs2_ok;
    endfunction

endpackage
